/* src/tcb_pkg.sv */
// shared definitions for the tightly coupled bus subsystem
//   bus widths and the default response delay
//   manager side byte order enum
//   data word union, seen as a whole word or as byte lanes
//   reference mode and memory mode request structs
//   response struct

package tcb_pkg;

  ////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////

  // address width in bits
  localparam int unsigned TCB_ABW = 16;
  // data width in bits
  localparam int unsigned TCB_DBW = 32;
  // byte lane count
  localparam int unsigned TCB_BEW = TCB_DBW / 8;

  // response delay in clock cycles, transfer edge to valid response
  localparam int unsigned TCB_DLY = 2;

  ////////////////////////////////////////
  // byte order
  ////////////////////////////////////////

  // descending means lane 0 holds the least significant byte
  typedef enum logic {
    TCB_DESCENDING = 1'b0,
    TCB_ASCENDING  = 1'b1
  } tcb_ord_t;

  ////////////////////////////////////////
  // data word
  ////////////////////////////////////////

  // same 32 bits, either as a plain word or as byte lanes
  typedef union packed {
    logic [TCB_DBW-1:0]         wrd;
    logic [TCB_BEW-1:0][8-1:0]  lane;
  } tcb_data_t;

  ////////////////////////////////////////
  // requests and response
  ////////////////////////////////////////

  // reference mode, data at the low bytes, size as log2 of byte count
  typedef struct packed {
    logic               wen;  // write enable
    logic               ndn;  // big endian when set
    logic [2-1:0]       siz;  // log2 of byte count
    logic [TCB_ABW-1:0] adr;  // byte address
    tcb_data_t          wdt;  // write data
  } tcb_ref_req_t;

  // memory mode, data on the lanes chosen by the address
  typedef struct packed {
    logic               wen;  // write enable
    logic [TCB_ABW-1:0] adr;  // byte address
    tcb_data_t          wdt;  // write data, lane steered
    logic [TCB_BEW-1:0] ben;  // byte enables
  } tcb_mem_req_t;

  // response, valid DLY cycles after the transfer edge
  typedef struct packed {
    tcb_data_t          rdt;  // read data
    logic               err;  // misaligned or out of range
  } tcb_rsp_t;

endpackage

/* src/tcb_lib_endianness.sv */
// reference mode to memory mode bus converter
//   misalignment flag from size and low address bits
//   write data lane steering, little or big endian
//   byte enable generation
//   read data return steering with zero fill of unused bytes
//   DLY deep pipeline of the request fields the return path needs

`timescale 1ns/1ps

module tcb_lib_endianness #(
  parameter int unsigned       DLY = tcb_pkg::TCB_DLY,
  parameter tcb_pkg::tcb_ord_t ORD = tcb_pkg::TCB_DESCENDING
)(
  input  logic                  clk,
  input  logic                  rst_n,
  // subordinate side in reference mode
  input  logic                  sub_vld,
  input  tcb_pkg::tcb_ref_req_t sub_req,
  output logic                  sub_rdy,
  output tcb_pkg::tcb_rsp_t     sub_rsp,
  // manager side in memory mode
  output logic                  man_vld,
  output tcb_pkg::tcb_mem_req_t man_req,
  input  logic                  man_rdy,
  input  tcb_pkg::tcb_rsp_t     man_rsp,
  // misaligned access
  output logic                  mal
);

  import tcb_pkg::*;

  // lane offset width
  localparam int unsigned OFW = $clog2(TCB_BEW);

  // request fields kept for the return path
  typedef struct packed {
    logic           ndn;
    logic [2-1:0]   siz;
    logic [OFW-1:0] off;
  } ret_t;

  // byte count from log2 size and capped at the bus width
  function automatic logic [OFW:0] byte_cnt(input logic [2-1:0] siz);
    logic [OFW:0] cnt;
    if (siz >= 2'(OFW)) begin
      cnt = (OFW+1)'(TCB_BEW);
    end else begin
      cnt = (OFW+1)'(1) << siz;
    end
    return cnt;
  endfunction

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  assign man_vld = sub_vld;
  assign sub_rdy = man_rdy;

  ////////////////////////////////////////
  // misalignment
  ////////////////////////////////////////

  // any of the low siz address bits set
  always_comb begin
    case (sub_req.siz)
      2'd0:    mal = 1'b0;
      2'd1:    mal = sub_req.adr[0];
      2'd2:    mal = |sub_req.adr[1:0];
      default: mal = |sub_req.adr[2:0];
    endcase
  end

  ////////////////////////////////////////
  // write steering
  ////////////////////////////////////////

  logic [OFW-1:0] req_off;
  logic [OFW:0]   req_cnt;
  // request byte that lands on each logical lane
  logic [OFW-1:0] sel_wdt [TCB_BEW];
  // logical lanes that take part in the access
  logic           lane_use [TCB_BEW];

  assign req_off = sub_req.adr[OFW-1:0];
  assign req_cnt = byte_cnt(sub_req.siz);

  always_comb begin
    for (int unsigned i = 0; i < TCB_BEW; i++) begin
      // little endian puts byte k on lane off+k and so k = i-off
      // big endian puts byte k on lane off+cnt-1-k
      if (sub_req.ndn) begin
        sel_wdt[i] = OFW'(req_off + req_cnt[OFW-1:0] - OFW'(1) - OFW'(i));
      end else begin
        sel_wdt[i] = OFW'(OFW'(i) - req_off);
      end
      // used lanes are the same set for both orders
      lane_use[i] = ({1'b0, OFW'(OFW'(i) - req_off)} < req_cnt);
    end
  end

  // logical to physical lane mapping reversed for ascending order
  always_comb begin
    man_req     = '0;
    man_req.wen = sub_req.wen;
    // memory ignores the low address bits
    man_req.adr = sub_req.adr;
    for (int unsigned i = 0; i < TCB_BEW; i++) begin
      if (ORD == TCB_ASCENDING) begin
        man_req.wdt.lane[TCB_BEW-1-i] = sub_req.wdt.lane[sel_wdt[i]];
        man_req.ben[TCB_BEW-1-i]      = lane_use[i];
      end else begin
        man_req.wdt.lane[i] = sub_req.wdt.lane[sel_wdt[i]];
        man_req.ben[i]      = lane_use[i];
      end
    end
  end

  ////////////////////////////////////////
  // return path
  ////////////////////////////////////////

  // one stage per cycle of response delay
  ret_t ret_dly [DLY];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int unsigned i = 0; i < DLY; i++) begin
        ret_dly[i] <= '0;
      end
    end else begin
      ret_dly[0] <= '{ndn: sub_req.ndn, siz: sub_req.siz, off: req_off};
      for (int unsigned i = 1; i < DLY; i++) begin
        ret_dly[i] <= ret_dly[i-1];
      end
    end
  end

  logic [OFW:0]   ret_cnt;
  logic [OFW-1:0] sel_rdt [TCB_BEW];

  assign ret_cnt = byte_cnt(ret_dly[DLY-1].siz);

  // inverse of the write mapping gives request byte k from a logical lane
  always_comb begin
    for (int unsigned k = 0; k < TCB_BEW; k++) begin
      if (ret_dly[DLY-1].ndn) begin
        sel_rdt[k] = OFW'(ret_dly[DLY-1].off + ret_cnt[OFW-1:0] - OFW'(1) - OFW'(k));
      end else begin
        sel_rdt[k] = OFW'(ret_dly[DLY-1].off + OFW'(k));
      end
    end
  end

  always_comb begin
    sub_rsp.err = man_rsp.err;
    for (int unsigned k = 0; k < TCB_BEW; k++) begin
      // bytes above the access size read as zero
      if ((OFW+1)'(k) >= ret_cnt) begin
        sub_rsp.rdt.lane[k] = '0;
      end else if (ORD == TCB_ASCENDING) begin
        sub_rsp.rdt.lane[k] = man_rsp.rdt.lane[~sel_rdt[k]];
      end else begin
        sub_rsp.rdt.lane[k] = man_rsp.rdt.lane[sel_rdt[k]];
      end
    end
  end

endmodule

/* src/tcb_lib_misalign_guard.sv */
// misaligned access guard between converter and memory
//   drops the memory side valid for misaligned requests
//   tracks blocked transfers through a DLY stage shift
//   replaces the memory response with an error when one is due

`timescale 1ns/1ps

module tcb_lib_misalign_guard #(
  parameter int unsigned DLY = tcb_pkg::TCB_DLY
)(
  input  logic                  clk,
  input  logic                  rst_n,
  // converter side
  input  logic                  sub_vld,
  input  tcb_pkg::tcb_mem_req_t sub_req,
  output logic                  sub_rdy,
  output tcb_pkg::tcb_rsp_t     sub_rsp,
  input  logic                  mal,
  // memory side
  output logic                  man_vld,
  output tcb_pkg::tcb_mem_req_t man_req,
  input  logic                  man_rdy,
  input  tcb_pkg::tcb_rsp_t     man_rsp
);

  ////////////////////////////////////////
  // request path
  ////////////////////////////////////////

  // misaligned requests never reach memory
  assign man_vld = sub_vld & ~mal;
  assign man_req = sub_req;

  // guard itself never stalls, follow the memory
  assign sub_rdy = man_rdy;

  ////////////////////////////////////////
  // blocked transfer tracking
  ////////////////////////////////////////

  logic blk;
  logic blk_dly [DLY];

  // transfer happened but was held back
  assign blk = sub_vld & sub_rdy & mal;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int unsigned i = 0; i < DLY; i++) blk_dly[i] <= 1'b0;
    end else begin
      blk_dly[0] <= blk;
      for (int unsigned i = 1; i < DLY; i++) blk_dly[i] <= blk_dly[i-1];
    end
  end

  ////////////////////////////////////////
  // response path
  ////////////////////////////////////////

  // error with empty data in the slot of a blocked transfer
  always_comb begin
    if (blk_dly[DLY-1]) begin
      sub_rsp.rdt.wrd = '0;
      sub_rsp.err     = 1'b1;
    end else begin
      sub_rsp = man_rsp;
    end
  end

endmodule

/* src/tcb_mem.sv */
// memory subordinate for the memory mode bus
//   word array indexed by the word address
//   byte enabled writes
//   range check, out of range accesses set err
//   DLY stage response pipeline
//   rdy register, high from the first cycle after reset

`timescale 1ns/1ps

module tcb_mem #(
  parameter int unsigned DLY   = tcb_pkg::TCB_DLY,
  parameter int unsigned DEPTH = 64
)(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  vld,
  input  tcb_pkg::tcb_mem_req_t req,
  output logic                  rdy,
  output tcb_pkg::tcb_rsp_t     rsp
);

  import tcb_pkg::*;

  // lane offset width and word address width
  localparam int unsigned OFW = $clog2(TCB_BEW);
  localparam int unsigned WAW = TCB_ABW - OFW;
  // array index width
  localparam int unsigned IDW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  logic           trn;
  logic [WAW-1:0] wadr;
  logic [IDW-1:0] idx;
  logic           oor;

  assign trn  = vld & rdy;
  // low address bits select lanes only
  assign wadr = req.adr[TCB_ABW-1:OFW];
  assign idx  = wadr[IDW-1:0];
  // word address at or above DEPTH
  assign oor  = (32'(wadr) >= 32'(DEPTH));

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  // never stalls once out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  tcb_data_t mem [DEPTH];

  // byte enabled write, out of range writes are dropped
  always_ff @(posedge clk) begin
    if (trn & req.wen & ~oor) begin
      for (int unsigned i = 0; i < TCB_BEW; i++) begin
        if (req.ben[i]) mem[idx].lane[i] <= req.wdt.lane[i];
      end
    end
  end

  ////////////////////////////////////////
  // response pipeline
  ////////////////////////////////////////

  tcb_rsp_t rsp_dly [DLY];

  always_ff @(posedge clk) begin
    // first stage, read data only for an in range read
    if (trn & ~req.wen & ~oor) begin
      rsp_dly[0].rdt <= mem[idx];
    end else begin
      rsp_dly[0].rdt.wrd <= '0;
    end
    rsp_dly[0].err <= trn & oor;
    // remaining stages just shift
    for (int unsigned i = 1; i < DLY; i++) rsp_dly[i] <= rsp_dly[i-1];
  end

  // last stage lines up with the transfer DLY cycles back
  assign rsp = rsp_dly[DLY-1];

endmodule

/* src/tcb_sys_top.sv */
// bus subsystem top level
//   reference to memory mode converter
//   misaligned access guard
//   memory subordinate

`timescale 1ns/1ps

module tcb_sys_top #(
  parameter int unsigned       DLY   = tcb_pkg::TCB_DLY,
  parameter tcb_pkg::tcb_ord_t ORD   = tcb_pkg::TCB_DESCENDING,
  parameter int unsigned       DEPTH = 64
)(
  input  logic                  clk,
  input  logic                  rst_n,
  // manager connects here, reference mode
  input  logic                  sub_vld,
  input  tcb_pkg::tcb_ref_req_t sub_req,
  output logic                  sub_rdy,
  output tcb_pkg::tcb_rsp_t     sub_rsp
);

  import tcb_pkg::*;

  ////////////////////////////////////////
  // converter to guard
  ////////////////////////////////////////

  logic         cnv_vld;
  tcb_mem_req_t cnv_req;
  logic         cnv_rdy;
  tcb_rsp_t     cnv_rsp;
  logic         cnv_mal;

  // guard to memory
  logic         mem_vld;
  tcb_mem_req_t mem_req;
  logic         mem_rdy;
  tcb_rsp_t     mem_rsp;

  ////////////////////////////////////////
  // instances
  ////////////////////////////////////////

  tcb_lib_endianness #(
    .DLY (DLY),
    .ORD (ORD)
  ) u_endianness (
    .clk     (clk),
    .rst_n   (rst_n),
    .sub_vld (sub_vld),
    .sub_req (sub_req),
    .sub_rdy (sub_rdy),
    .sub_rsp (sub_rsp),
    .man_vld (cnv_vld),
    .man_req (cnv_req),
    .man_rdy (cnv_rdy),
    .man_rsp (cnv_rsp),
    .mal     (cnv_mal)
  );

  tcb_lib_misalign_guard #(
    .DLY (DLY)
  ) u_guard (
    .clk     (clk),
    .rst_n   (rst_n),
    .sub_vld (cnv_vld),
    .sub_req (cnv_req),
    .sub_rdy (cnv_rdy),
    .sub_rsp (cnv_rsp),
    .mal     (cnv_mal),
    .man_vld (mem_vld),
    .man_req (mem_req),
    .man_rdy (mem_rdy),
    .man_rsp (mem_rsp)
  );

  tcb_mem #(
    .DLY   (DLY),
    .DEPTH (DEPTH)
  ) u_mem (
    .clk   (clk),
    .rst_n (rst_n),
    .vld   (mem_vld),
    .req   (mem_req),
    .rdy   (mem_rdy),
    .rsp   (mem_rsp)
  );

endmodule

/* sim/tcb_sys_checker.sv */
// response checker for the bus subsystem testbench
//   records each transfer with its expected response
//   compares sub_rsp in the cycle the response is due
//   watches rdy after reset
//   error count and closing line

`timescale 1ns/1ps

module tcb_sys_checker #(
  parameter int unsigned DLY = tcb_pkg::TCB_DLY
)(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              sub_vld,
  input  logic              sub_rdy,
  input  tcb_pkg::tcb_rsp_t sub_rsp,
  input  tcb_pkg::tcb_rsp_t exp_rsp,
  input  logic              report,
  output int unsigned       err_cnt,
  output int unsigned       pending
);

  import tcb_pkg::*;

  // expected responses and the cycle each one is due
  tcb_rsp_t    exp_q [$];
  int unsigned due_q [$];
  int unsigned cyc;
  // falling edges since reset release, saturates at 2
  int unsigned rst_cyc;
  int unsigned chk_cnt;
  bit          reported;

  ////////////////////////////////////////
  // sampled on the falling edge
  ////////////////////////////////////////

  always @(negedge clk) begin
    tcb_rsp_t want;
    if (!rst_n) begin
      cyc     = 0;
      rst_cyc = 0;
    end else begin
      cyc++;
      if (rst_cyc < 2) rst_cyc++;
      // one cycle of rdy low right after reset is expected
      if (rst_cyc >= 2 && sub_rdy !== 1'b1) begin
        err_cnt++;
        $display("sub_rdy is low at time %0t although reset has ended", $time);
      end
      // response from the stage that lines up with its transfer
      if (due_q.size() > 0 && due_q[0] == cyc) begin
        want = exp_q.pop_front();
        due_q.delete(0);
        chk_cnt++;
        if (sub_rsp.rdt.wrd !== want.rdt.wrd) begin
          err_cnt++;
          $display("[ERROR] sub_rsp.rdt expected 0x%08h actual 0x%08h at time %0t",
                   want.rdt.wrd, sub_rsp.rdt.wrd, $time);
        end
        if (sub_rsp.err !== want.err) begin
          err_cnt++;
          $display("[ERROR] sub_rsp.err expected 0x%0h actual 0x%0h at time %0t",
                   want.err, sub_rsp.err, $time);
        end
      end
      // transfer on the coming rising edge, due DLY edges later
      if (sub_vld === 1'b1 && sub_rdy === 1'b1) begin
        exp_q.push_back(exp_rsp);
        due_q.push_back(cyc + DLY);
      end
      pending = due_q.size();
    end
    if (report && !reported) begin
      reported = 1'b1;
      if (due_q.size() != 0) begin
        err_cnt++;
        $display("%0d responses were never checked", due_q.size());
      end
      $display("checker: %0d responses checked, %0d errors", chk_cnt, err_cnt);
    end
  end

endmodule

/* sim/tcb_sys_tb.sv */
// testbench top for the bus subsystem
//   clock and reset generation
//   request stimulus read from the test vector file
//   watchdog sized from the number of vectors
//   DUT and response checker instances

`timescale 1ns/1ps

module tcb_sys_tb;

  import tcb_pkg::*;

  localparam int unsigned DLY      = TCB_DLY;
  localparam int unsigned DEPTH    = 64;
  localparam int unsigned CLK_NS   = 4;
  localparam int unsigned RST_CYC  = 10;
  localparam int unsigned MAX_RECS = 64;
  localparam int unsigned IDXW     = $clog2(MAX_RECS);

  // one test vector, every field starts on a hex digit
  typedef struct packed {
    logic [3:0]  vld;
    logic [3:0]  wen;
    logic [3:0]  ndn;
    logic [3:0]  siz;
    logic [15:0] adr;
    logic [31:0] wdt;
    logic [31:0] rdt;
    logic [3:0]  err;
  } vec_t;

  logic [$bits(vec_t)-1:0] vec_mem [MAX_RECS];

  logic         clk;
  logic         rst_n;
  logic         sub_vld;
  tcb_ref_req_t sub_req;
  logic         sub_rdy;
  tcb_rsp_t     sub_rsp;
  // expected response, travels with the request
  tcb_rsp_t     exp_rsp;
  logic         report;
  logic         loaded;
  int unsigned  num_tests;
  int unsigned  err_cnt;
  int unsigned  pending;

  ////////////////////////////////////////
  // DUT and checker
  ////////////////////////////////////////

  tcb_sys_top #(
    .DLY   (DLY),
    .ORD   (TCB_DESCENDING),
    .DEPTH (DEPTH)
  ) u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .sub_vld (sub_vld),
    .sub_req (sub_req),
    .sub_rdy (sub_rdy),
    .sub_rsp (sub_rsp)
  );

  tcb_sys_checker #(
    .DLY (DLY)
  ) u_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .sub_vld (sub_vld),
    .sub_rdy (sub_rdy),
    .sub_rsp (sub_rsp),
    .exp_rsp (exp_rsp),
    .report  (report),
    .err_cnt (err_cnt),
    .pending (pending)
  );

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_NS/2) clk = ~clk;
  end

  task automatic drive_idle();
    sub_vld = 1'b0;
    sub_req = '0;
    exp_rsp = '0;
  endtask

  task automatic drive_vec(input vec_t v);
    sub_vld         = v.vld[0];
    sub_req.wen     = v.wen[0];
    sub_req.ndn     = v.ndn[0];
    sub_req.siz     = v.siz[1:0];
    sub_req.adr     = v.adr;
    sub_req.wdt.wrd = v.wdt;
    exp_rsp.rdt.wrd = v.rdt;
    exp_rsp.err     = v.err[0];
  endtask

  initial begin
    loaded = 1'b0;
    report = 1'b0;
    rst_n  = 1'b0;
    drive_idle();
    // all ones marks the end of the loaded vectors
    for (int unsigned i = 0; i < MAX_RECS; i++) begin
      vec_mem[IDXW'(i)] = '1;
    end
    $readmemh("sim/tcb_sys_tests.hex", vec_mem);
    num_tests = 0;
    while (num_tests < MAX_RECS && vec_mem[IDXW'(num_tests)][99:96] != 4'hf) begin
      num_tests++;
    end
    loaded = 1'b1;
    repeat (RST_CYC) @(posedge clk);
    #1 rst_n = 1'b1;
    // memory raises rdy one cycle after reset
    do begin
      @(posedge clk);
      #1;
    end while (sub_rdy !== 1'b1);
    // one vector per cycle, back to back
    for (int unsigned n = 0; n < num_tests; n++) begin
      drive_vec(vec_t'(vec_mem[IDXW'(n)]));
      @(posedge clk);
      #1;
    end
    drive_idle();
    // drain the responses still in flight
    wait (pending == 0);
    report = 1'b1;
    @(negedge clk);
    #1;
    if (num_tests == 0) begin
      $display("no test vectors were loaded from sim/tcb_sys_tests.hex");
    end
    if (err_cnt == 0 && num_tests > 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  ////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////

  initial begin
    int unsigned limit_ns;
    wait (loaded);
    limit_ns = (num_tests + DLY + 20) * CLK_NS + RST_CYC * CLK_NS;
    #(limit_ns);
    $display("watchdog expired after %0d ns with responses still outstanding", limit_ns);
    report = 1'b1;
    @(negedge clk);
    #1;
    $display("Simulation failed");
    $finish;
  end

endmodule

/* sim/tcb_sys_tests.hex */
// columns vld_wen_ndn_siz_adr_wdt_rdt_err, one transfer per line
// rdt and err give the response expected DLY cycles after the transfer
1_1_0_2_0000_11223344_00000000_0
1_0_0_2_0000_00000000_11223344_0
1_1_0_2_0004_a0a1a2a3_00000000_0
1_1_0_0_0004_deadbe11_00000000_0
1_1_0_0_0006_00000022_00000000_0
1_0_0_2_0004_00000000_a022a211_0
1_1_0_0_0005_00000033_00000000_0
1_1_0_0_0007_00000044_00000000_0
1_0_0_2_0004_00000000_44223311_0
0_0_0_0_0000_00000000_00000000_0
1_1_0_2_0008_c0c1c2c3_00000000_0
1_1_0_1_000a_ffff5566_00000000_0
1_1_0_1_0008_00007788_00000000_0
1_0_0_2_0008_00000000_55667788_0
1_0_0_0_0009_00000000_00000077_0
1_0_0_1_000a_00000000_00005566_0
1_0_1_1_000a_00000000_00006655_0
1_0_1_2_0008_00000000_88776655_0
1_1_1_2_000c_01020304_00000000_0
1_0_0_2_000c_00000000_04030201_0
1_1_1_1_0012_eeeeabcd_00000000_0
1_0_0_1_0012_00000000_0000cdab_0
1_1_0_2_0001_badbad00_00000000_1
1_1_0_1_0003_00009999_00000000_1
1_0_0_1_0005_00000000_00000000_1
1_0_0_2_0000_00000000_11223344_0
1_1_0_2_0100_12345678_00000000_1
1_0_0_2_fffc_00000000_00000000_1
1_0_0_2_0000_00000000_11223344_0

/* tb.f */
src/tcb_pkg.sv
src/tcb_lib_endianness.sv
src/tcb_lib_misalign_guard.sv
src/tcb_mem.sv
src/tcb_sys_top.sv
sim/tcb_sys_checker.sv
sim/tcb_sys_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the bus subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --top-module tcb_sys_tb -f tb.f -o tcb_sys_sim || exit 1
out=$(./obj_dir/tcb_sys_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Simulation passed" && exit 0 || exit 1
